/* sources.f */
src/ctrl_pkg.sv
src/hazard_pkg.sv
src/ctrl_fsm.sv
src/hazard_unit.sv
src/fwd_unit.sv
src/ctrl_top.sv
bench/ctrl_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --timescale 1ns/10ps
TOP       = ctrl_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/ctrl_tb.sv */
//////////////////////////////
// controller testbench: clock, reset, lfsr stimulus,
// reference models, directed and random tests, timeout
//////////////////////////////

`timescale 1ns/10ps

module ctrl_tb import ctrl_pkg::*, hazard_pkg::*;;

  localparam int IRQ_ID_W   = 5;
  localparam int REG_ADDR_W = 6;
  // about twice the summed length of all tests
  localparam int MAX_CYCLES = 2000;

  logic clk = 1'b0;
  logic rst_n;

  // dut inputs
  logic                  fetch_enable_i, instr_valid_i, id_ready_i, ex_valid_i;
  dec_flags_t            dec_i;
  jump_kind_e            jump_in_dec_i, jump_in_id_i;
  logic                  branch_taken_ex_i;
  logic                  irq_i, irq_req_i, m_ie_i;
  logic [IRQ_ID_W-1:0]   irq_id_i;
  pipe_wr_t              pipe_wr_i;
  op_hit_t               hit_ex_i, hit_wb_i, hit_alu_i;
  logic                  regfile_we_id_i;
  logic [REG_ADDR_W-1:0] regfile_waddr_ex_i, regfile_alu_waddr_id_i;
  logic                  data_misaligned_i, mult_multicycle_i;

  // dut outputs
  logic               instr_req_o, ctrl_busy_o, pc_set_o, irq_ack_o, exc_kill_o;
  pc_mux_e            pc_mux_o;
  logic [CAUSE_W-1:0] exc_cause_o;
  csr_cmd_t           csr_o;
  logic               halt_if_o, halt_id_o;
  logic               deassert_we_o, load_stall_o, jr_stall_o;
  fwd_sel_t           fwd_sel_o;

  // bench state
  logic [31:0] lfsr;
  int          errors = 0;
  int          cycles = 0;
  int          pulses;
  string       test_name;
  logic        chk_fwd, chk_haz, exp_dec_active;
  logic [5:0]  exp_fwd;
  logic [2:0]  exp_haz;

  ctrl_top #(
    .IRQ_ID_W   (IRQ_ID_W),
    .REG_ADDR_W (REG_ADDR_W)
  ) i_ctrl_top (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .instr_valid_i          (instr_valid_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    .dec_i                  (dec_i),
    .jump_in_dec_i          (jump_in_dec_i),
    .jump_in_id_i           (jump_in_id_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .irq_i                  (irq_i),
    .irq_req_i              (irq_req_i),
    .irq_id_i               (irq_id_i),
    .m_ie_i                 (m_ie_i),
    .pipe_wr_i              (pipe_wr_i),
    .hit_ex_i               (hit_ex_i),
    .hit_wb_i               (hit_wb_i),
    .hit_alu_i              (hit_alu_i),
    .regfile_we_id_i        (regfile_we_id_i),
    .regfile_waddr_ex_i     (regfile_waddr_ex_i),
    .regfile_alu_waddr_id_i (regfile_alu_waddr_id_i),
    .data_misaligned_i      (data_misaligned_i),
    .mult_multicycle_i      (mult_multicycle_i),
    .instr_req_o            (instr_req_o),
    .ctrl_busy_o            (ctrl_busy_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .exc_cause_o            (exc_cause_o),
    .irq_ack_o              (irq_ack_o),
    .exc_kill_o             (exc_kill_o),
    .csr_o                  (csr_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o),
    .deassert_we_o          (deassert_we_o),
    .load_stall_o           (load_stall_o),
    .jr_stall_o             (jr_stall_o),
    .fwd_sel_o              (fwd_sel_o)
  );

  // 4 ns period
  always #2 clk = ~clk;

  //////////////////////////////
  // random source and reference models
  //////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // bit 2 is operand a, bit 0 operand c
  function automatic logic [5:0] ref_fwd(input pipe_wr_t wr, input logic [2:0] wb,
                                         input logic [2:0] alu, input logic mis,
                                         input logic mult);
    logic [5:0] s;
    for (int i = 0; i < 3; i++) begin
      s[2*i +: 2] = 2'd0;
      if (wr.wb_we && wb[i]) begin
        s[2*i +: 2] = 2'd2;
      end
      // younger ex result overrides wb
      if (wr.alu_we_fw && alu[i]) begin
        s[2*i +: 2] = 2'd1;
      end
    end
    if (mis) begin
      s[5:4] = 2'd1;
      s[3:2] = 2'd0;
    end else if (mult) begin
      s[1:0] = 2'd1;
    end
    return s;
  endfunction

  // result is {load_stall, jr_stall, deassert_we}
  function automatic logic [2:0] ref_hazard(input logic act, input jump_kind_e jk,
                                            input pipe_wr_t wr, input logic [2:0] ex,
                                            input logic [2:0] wb, input logic [2:0] alu,
                                            input logic we_id,
                                            input logic [REG_ADDR_W-1:0] wa_ex,
                                            input logic [REG_ADDR_W-1:0] wa_id);
    logic pend, need, ld, jr;
    pend = (wr.ex_data_req && wr.ex_we) || (wr.wb_we && !wr.wb_ready);
    need = (ex != 3'b000) || (act && we_id && (wa_ex == wa_id));
    ld   = pend && need;
    // operand a feeds the jalr target
    jr   = (jk == JUMP_JALR) &&
           ((wr.wb_we && wb[2]) || (wr.ex_we && ex[2]) || (wr.alu_we_fw && alu[2]));
    return {ld, jr, !act || ld || jr};
  endfunction

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_inputs();
    instr_valid_i          = 1'b0;
    id_ready_i             = 1'b0;
    ex_valid_i             = 1'b0;
    dec_i                  = '0;
    jump_in_dec_i          = JUMP_NONE;
    jump_in_id_i           = JUMP_NONE;
    branch_taken_ex_i      = 1'b0;
    irq_i                  = 1'b0;
    irq_req_i              = 1'b0;
    irq_id_i               = '0;
    m_ie_i                 = 1'b0;
    pipe_wr_i              = '0;
    hit_ex_i               = '0;
    hit_wb_i               = '0;
    hit_alu_i              = '0;
    regfile_we_id_i        = 1'b0;
    regfile_waddr_ex_i     = '0;
    regfile_alu_waddr_id_i = '0;
    data_misaligned_i      = 1'b0;
    mult_multicycle_i      = 1'b0;
    exp_dec_active         = 1'b0;
  endtask

  // narrow address range so the compare term hits often
  task automatic drive_random(input logic valid_instr);
    logic [31:0] v;
    draw(5, v);
    pipe_wr_i = pipe_wr_t'(v[4:0]);
    draw(3, v);
    hit_ex_i = op_hit_t'(v[2:0]);
    draw(3, v);
    hit_wb_i = op_hit_t'(v[2:0]);
    draw(3, v);
    hit_alu_i = op_hit_t'(v[2:0]);
    draw(1, v);
    regfile_we_id_i = v[0];
    draw(2, v);
    regfile_waddr_ex_i = REG_ADDR_W'(v[1:0]);
    draw(2, v);
    regfile_alu_waddr_id_i = REG_ADDR_W'(v[1:0]);
    // overrides on roughly one cycle in four
    draw(2, v);
    data_misaligned_i = &v[1:0];
    draw(2, v);
    mult_multicycle_i = &v[1:0];
    draw(2, v);
    if (valid_instr) begin
      jump_in_dec_i = v[0] ? JUMP_COND : JUMP_NONE;
    end else begin
      jump_in_dec_i = jump_kind_e'(v[1:0]);
    end
    instr_valid_i  = valid_instr;
    exp_dec_active = valid_instr;
  endtask

  //////////////////////////////
  // directed sequences
  //////////////////////////////

  task automatic boot_test();
    test_name = "boot";
    // reset state: no fetch, no redirect, no csr traffic, busy
    repeat (3) begin
      next_cycle();
      @(negedge clk);
      if ({instr_req_o, pc_set_o, irq_ack_o, exc_kill_o, ctrl_busy_o, csr_o} !==
          {5'b00001, 10'b0}) begin
        $display("ERR %s: req/set/ack/kill/busy/csr expected %b actual %b", test_name,
                 {5'b00001, 10'b0},
                 {instr_req_o, pc_set_o, irq_ack_o, exc_kill_o, ctrl_busy_o, csr_o});
        errors++;
      end
    end
    next_cycle();
    fetch_enable_i = 1'b1;
    // boot pulse one cycle after the enable is seen
    next_cycle();
    @(negedge clk);
    if ({pc_set_o, pc_mux_o, instr_req_o} !== {1'b1, PC_BOOT, 1'b1}) begin
      $display("ERR %s: set/mux/req expected %h actual %h", test_name,
               {1'b1, PC_BOOT, 1'b1}, {pc_set_o, pc_mux_o, instr_req_o});
      errors++;
    end
    // id not ready yet, fetch stays requested
    repeat (3) begin
      next_cycle();
      id_ready_i = 1'b1;
      @(negedge clk);
      if ({instr_req_o, pc_set_o} !== 2'b10) begin
        $display("ERR %s: req/set expected %b actual %b", test_name, 2'b10,
                 {instr_req_o, pc_set_o});
        errors++;
      end
    end
  endtask

  // ex_valid held high, so the redirect comes two cycles after decode
  task automatic run_trap(input string name, input dec_flags_t flags,
                          input logic [CAUSE_W-1:0] cause);
    test_name  = name;
    ex_valid_i = 1'b1;
    next_cycle();
    instr_valid_i = 1'b1;
    dec_i         = flags;
    @(negedge clk);
    // save_id and save_cause only
    if (csr_o !== {4'b0110, cause}) begin
      $display("ERR %s: csr save expected %h actual %h", test_name, {4'b0110, cause},
               csr_o);
      errors++;
    end
    // flush cycle, fetch and decode held, no redirect yet
    next_cycle();
    @(negedge clk);
    if ({halt_if_o, halt_id_o, pc_set_o} !== 3'b110) begin
      $display("ERR %s: halt if/id/set expected %b actual %b", test_name, 3'b110,
               {halt_if_o, halt_id_o, pc_set_o});
      errors++;
    end
    next_cycle();
    @(negedge clk);
    if ({pc_set_o, pc_mux_o, exc_cause_o} !== {1'b1, PC_EXCEPTION, cause}) begin
      $display("ERR %s: set/mux/cause expected %h actual %h", test_name,
               {1'b1, PC_EXCEPTION, cause}, {pc_set_o, pc_mux_o, exc_cause_o});
      errors++;
    end
    next_cycle();
    instr_valid_i = 1'b0;
    dec_i         = '0;
  endtask

  task automatic run_irq(input logic keep_irq);
    logic [31:0]        v;
    logic [CAUSE_W-1:0] exp_cause;
    test_name = keep_irq ? "irq_take" : "irq_kill";
    draw(IRQ_ID_W, v);
    exp_cause = CAUSE_W'(1 << IRQ_ID_W) | CAUSE_W'(v[IRQ_ID_W-1:0]);
    next_cycle();
    instr_valid_i = 1'b1;
    irq_req_i     = 1'b1;
    irq_i         = 1'b1;
    m_ie_i        = 1'b1;
    irq_id_i      = v[IRQ_ID_W-1:0];
    // flush cycle, the line may already be gone
    next_cycle();
    instr_valid_i = 1'b0;
    irq_req_i     = 1'b0;
    irq_i         = keep_irq;
    @(negedge clk);
    if ({halt_if_o, halt_id_o} !== 2'b11) begin
      $display("ERR %s: halt if/id expected %b actual %b", test_name, 2'b11,
               {halt_if_o, halt_id_o});
      errors++;
    end
    if (!keep_irq && {exc_kill_o, irq_ack_o} !== 2'b10) begin
      $display("ERR %s: kill/ack expected %b actual %b", test_name, 2'b10,
               {exc_kill_o, irq_ack_o});
      errors++;
    end
    next_cycle();
    @(negedge clk);
    if (keep_irq) begin
      if ({pc_set_o, pc_mux_o, irq_ack_o, csr_o} !==
          {1'b1, PC_EXCEPTION, 1'b1, 4'b0110, exp_cause}) begin
        $display("ERR %s: set/mux/ack/csr expected %h actual %h", test_name,
                 {1'b1, PC_EXCEPTION, 1'b1, 4'b0110, exp_cause},
                 {pc_set_o, pc_mux_o, irq_ack_o, csr_o});
        errors++;
      end
    end else if ({pc_set_o, irq_ack_o} !== 2'b00) begin
      $display("ERR %s: set/ack expected %b actual %b", test_name, 2'b00,
               {pc_set_o, irq_ack_o});
      errors++;
    end
    next_cycle();
    irq_i  = 1'b0;
    m_ie_i = 1'b0;
  endtask

  //////////////////////////////
  // compare process for the combinational units
  //////////////////////////////

  always @(negedge clk) begin
    if (chk_fwd) begin
      exp_fwd = ref_fwd(pipe_wr_i, hit_wb_i, hit_alu_i, data_misaligned_i, mult_multicycle_i);
      if (fwd_sel_o !== exp_fwd) begin
        $display("ERR %s: fwd_sel expected %h actual %h", test_name, exp_fwd, fwd_sel_o);
        errors++;
      end
    end
    if (chk_haz) begin
      exp_haz = ref_hazard(exp_dec_active, jump_in_dec_i, pipe_wr_i, hit_ex_i, hit_wb_i,
                           hit_alu_i, regfile_we_id_i, regfile_waddr_ex_i,
                           regfile_alu_waddr_id_i);
      if ({load_stall_o, jr_stall_o, deassert_we_o} !== exp_haz) begin
        $display("ERR %s: load/jr/deassert expected %b actual %b", test_name, exp_haz,
                 {load_stall_o, jr_stall_o, deassert_we_o});
        errors++;
      end
      // nothing decoding, so id must never write
      if (!exp_dec_active && deassert_we_o !== 1'b1) begin
        $display("ERR %s: deassert_we expected 1 actual %b", test_name, deassert_we_o);
        errors++;
      end
    end
  end

  // hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles, errors: %0d", MAX_CYCLES, errors);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    lfsr           = 32'hc0ec;
    chk_fwd        = 1'b0;
    chk_haz        = 1'b0;
    test_name      = "reset";
    fetch_enable_i = 1'b0;
    clear_inputs();
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // ends in decode with id ready
    boot_test();

    test_name = "forwarding";
    chk_fwd   = 1'b1;
    repeat (300) begin
      next_cycle();
      drive_random(1'b0);
    end

    // no valid instruction, dec_active stays low
    test_name = "stall_idle";
    chk_haz   = 1'b1;
    repeat (300) begin
      next_cycle();
      drive_random(1'b0);
    end

    // legal non-jump instruction, address compare now counts
    test_name = "stall_decode";
    repeat (300) begin
      next_cycle();
      drive_random(1'b1);
    end
    next_cycle();
    chk_fwd = 1'b0;
    chk_haz = 1'b0;
    clear_inputs();

    // flag order illegal, ecall, ebrk, mret
    run_trap("trap_illegal", 4'b1000, 6'd2);
    run_trap("trap_ecall", 4'b0100, 6'd11);
    run_trap("trap_ebreak", 4'b0010, 6'd3);

    run_irq(1'b1);
    run_irq(1'b0);

    test_name  = "mret";
    ex_valid_i = 1'b1;
    next_cycle();
    instr_valid_i = 1'b1;
    dec_i         = 4'b0001;
    next_cycle();
    next_cycle();
    @(negedge clk);
    if ({csr_o.restore_mret, pc_set_o} !== 2'b10) begin
      $display("ERR %s: restore/set expected %b actual %b", test_name, 2'b10,
               {csr_o.restore_mret, pc_set_o});
      errors++;
    end
    next_cycle();
    instr_valid_i = 1'b0;
    dec_i         = '0;
    @(negedge clk);
    if ({pc_set_o, pc_mux_o} !== {1'b1, PC_MRET}) begin
      $display("ERR %s: set/mux expected %h actual %h", test_name, {1'b1, PC_MRET},
               {pc_set_o, pc_mux_o});
      errors++;
    end

    // id held stalled, the jump must fire only once
    test_name = "jump";
    next_cycle();
    instr_valid_i = 1'b1;
    jump_in_dec_i = JUMP_JAL;
    id_ready_i    = 1'b0;
    pulses        = 0;
    repeat (5) begin
      @(negedge clk);
      if (pc_set_o) begin
        pulses++;
        if (pc_mux_o !== PC_JUMP) begin
          $display("ERR %s: pc_mux expected %h actual %h", test_name, PC_JUMP, pc_mux_o);
          errors++;
        end
      end
      next_cycle();
    end
    instr_valid_i = 1'b0;
    jump_in_dec_i = JUMP_NONE;
    id_ready_i    = 1'b1;
    if (pulses != 1) begin
      $display("ERR %s: jump pulses expected 1 actual %0d", test_name, pulses);
      errors++;
    end

    next_cycle();
    $display("tests done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* src/ctrl_top.sv */
//////////////////////////////
// controller top: fsm, hazard unit and forwarding unit
//////////////////////////////

`timescale 1ns/10ps

module ctrl_top import ctrl_pkg::*, hazard_pkg::*; #(
  parameter int IRQ_ID_W   = 5,
  parameter int REG_ADDR_W = 6
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // pipeline status
  input  logic                  fetch_enable_i,
  input  logic                  instr_valid_i,
  input  logic                  id_ready_i,
  input  logic                  ex_valid_i,
  input  dec_flags_t            dec_i,
  input  jump_kind_e            jump_in_dec_i,
  input  jump_kind_e            jump_in_id_i,
  input  logic                  branch_taken_ex_i,
  // interrupt controller
  input  logic                  irq_i,
  input  logic                  irq_req_i,
  input  logic [IRQ_ID_W-1:0]   irq_id_i,
  input  logic                  m_ie_i,
  // operand and register write info
  input  pipe_wr_t              pipe_wr_i,
  input  op_hit_t               hit_ex_i,
  input  op_hit_t               hit_wb_i,
  input  op_hit_t               hit_alu_i,
  input  logic                  regfile_we_id_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_ex_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_id_i,
  input  logic                  data_misaligned_i,
  input  logic                  mult_multicycle_i,
  // fetch and trap control
  output logic                  instr_req_o,
  output logic                  ctrl_busy_o,
  output logic                  pc_set_o,
  output pc_mux_e               pc_mux_o,
  output logic [CAUSE_W-1:0]    exc_cause_o,
  output logic                  irq_ack_o,
  output logic                  exc_kill_o,
  output csr_cmd_t              csr_o,
  output logic                  halt_if_o,
  output logic                  halt_id_o,
  // stalls and forwarding
  output logic                  deassert_we_o,
  output logic                  load_stall_o,
  output logic                  jr_stall_o,
  output fwd_sel_t              fwd_sel_o
);

  logic dec_active;

  ctrl_fsm #(
    .IRQ_ID_W (IRQ_ID_W)
  ) i_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .dec_i             (dec_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .jump_in_id_i      (jump_in_id_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .irq_i             (irq_i),
    .irq_req_i         (irq_req_i),
    .irq_id_i          (irq_id_i),
    .m_ie_i            (m_ie_i),
    .jr_stall_i        (jr_stall_o),
    .instr_req_o       (instr_req_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_cause_o       (exc_cause_o),
    .irq_ack_o         (irq_ack_o),
    .exc_kill_o        (exc_kill_o),
    .csr_o             (csr_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .dec_active_o      (dec_active)
  );

  hazard_unit #(
    .REG_ADDR_W (REG_ADDR_W)
  ) i_hazard_unit (
    .dec_active_i           (dec_active),
    .jump_in_dec_i          (jump_in_dec_i),
    .pipe_wr_i              (pipe_wr_i),
    .hit_ex_i               (hit_ex_i),
    .hit_wb_i               (hit_wb_i),
    .hit_alu_i              (hit_alu_i),
    .regfile_we_id_i        (regfile_we_id_i),
    .regfile_waddr_ex_i     (regfile_waddr_ex_i),
    .regfile_alu_waddr_id_i (regfile_alu_waddr_id_i),
    .load_stall_o           (load_stall_o),
    .jr_stall_o             (jr_stall_o),
    .deassert_we_o          (deassert_we_o)
  );

  // purely combinational, fed from the pipeline
  fwd_unit i_fwd_unit (
    .pipe_wr_i         (pipe_wr_i),
    .hit_wb_i          (hit_wb_i),
    .hit_alu_i         (hit_alu_i),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .fwd_sel_o         (fwd_sel_o)
  );

endmodule

/* src/fwd_unit.sv */
//////////////////////////////
// operand forwarding selects for a, b and c
//////////////////////////////

`timescale 1ns/10ps

module fwd_unit import hazard_pkg::*; (
  input  pipe_wr_t pipe_wr_i,
  input  op_hit_t  hit_wb_i,
  input  op_hit_t  hit_alu_i,
  input  logic     data_misaligned_i,
  input  logic     mult_multicycle_i,
  output fwd_sel_t fwd_sel_o
);

  // ex result is younger than wb, so it wins
  function automatic fwd_sel_e pick_src(input logic wb_hit, input logic alu_hit);
    fwd_sel_e sel;
    sel = SEL_REGFILE;
    if (pipe_wr_i.wb_we && wb_hit) begin
      sel = SEL_FW_WB;
    end
    if (pipe_wr_i.alu_we_fw && alu_hit) begin
      sel = SEL_FW_EX;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_sel_o.a = pick_src(hit_wb_i.a, hit_alu_i.a);
    fwd_sel_o.b = pick_src(hit_wb_i.b, hit_alu_i.b);
    fwd_sel_o.c = pick_src(hit_wb_i.c, hit_alu_i.c);

    if (data_misaligned_i) begin
      // second half of a split access reuses the address from ex
      fwd_sel_o.a = SEL_FW_EX;
      fwd_sel_o.b = SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      // multicycle mult keeps its partial result on operand c
      fwd_sel_o.c = SEL_FW_EX;
    end
  end

endmodule

/* src/hazard_unit.sv */
//////////////////////////////
// load-use and jump-register stall detection,
// write enable deassertion
//////////////////////////////

`timescale 1ns/10ps

module hazard_unit import ctrl_pkg::*, hazard_pkg::*; #(
  parameter int REG_ADDR_W = 6
) (
  input  logic                  dec_active_i,
  input  jump_kind_e            jump_in_dec_i,
  input  pipe_wr_t              pipe_wr_i,
  input  op_hit_t               hit_ex_i,
  input  op_hit_t               hit_wb_i,
  input  op_hit_t               hit_alu_i,
  input  logic                  regfile_we_id_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_ex_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_id_i,
  output logic                  load_stall_o,
  output logic                  jr_stall_o,
  output logic                  deassert_we_o
);

  logic load_pending;
  logic load_needed;
  logic waw_ex;
  logic ra_busy;

  // load in ex, or wb still waiting for its data
  assign load_pending = (pipe_wr_i.ex_data_req & pipe_wr_i.ex_we) |
                        (pipe_wr_i.wb_we & ~pipe_wr_i.wb_ready);

  // id writes the same register the load will write
  assign waw_ex = dec_active_i & regfile_we_id_i &
                  (regfile_waddr_ex_i == regfile_alu_waddr_id_i);

  // any operand reads the load destination
  assign load_needed = hit_ex_i.a | hit_ex_i.b | hit_ex_i.c | waw_ex;

  assign load_stall_o = load_pending & load_needed;

  // jalr base register still being produced
  assign ra_busy = (pipe_wr_i.wb_we & hit_wb_i.a) |
                   (pipe_wr_i.ex_we & hit_ex_i.a) |
                   (pipe_wr_i.alu_we_fw & hit_alu_i.a);

  // the pc is fed straight from the regfile, so no forwarding here
  assign jr_stall_o = (jump_in_dec_i == JUMP_JALR) & ra_busy;

  // no write from id unless it is really decoding and not stalled
  assign deassert_we_o = ~dec_active_i | load_stall_o | jr_stall_o;

endmodule

/* src/ctrl_fsm.sv */
//////////////////////////////
// main control fsm: boot, decode steering,
// synchronous traps, interrupts and mret
//////////////////////////////

`timescale 1ns/10ps

module ctrl_fsm import ctrl_pkg::*; #(
  parameter int IRQ_ID_W = 5
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fetch_enable_i,
  input  logic                instr_valid_i,
  input  logic                id_ready_i,
  input  logic                ex_valid_i,
  input  dec_flags_t          dec_i,
  input  jump_kind_e          jump_in_dec_i,
  input  jump_kind_e          jump_in_id_i,
  input  logic                branch_taken_ex_i,
  input  logic                irq_i,
  input  logic                irq_req_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  input  logic                m_ie_i,
  input  logic                jr_stall_i,
  output logic                instr_req_o,
  output logic                ctrl_busy_o,
  output logic                pc_set_o,
  output pc_mux_e             pc_mux_o,
  output logic [CAUSE_W-1:0]  exc_cause_o,
  output logic                irq_ack_o,
  output logic                exc_kill_o,
  output csr_cmd_t            csr_o,
  output logic                halt_if_o,
  output logic                halt_id_o,
  output logic                dec_active_o
);

  ctrl_state_e        state_q, state_n;
  logic               jump_done_q, jump_done_n;
  logic               illegal_q, illegal_n;
  logic               irq_pending;
  logic               jump_in_dec;
  logic [CAUSE_W-1:0] irq_cause;

  // only the machine enable bit gates interrupts
  assign irq_pending = irq_req_i & m_ie_i;
  // unconditional jumps are resolved in decode
  assign jump_in_dec = (jump_in_dec_i == JUMP_JAL) || (jump_in_dec_i == JUMP_JALR);
  // interrupt cause carries the top bit above the id
  assign irq_cause   = CAUSE_W'({1'b1, irq_id_i});

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb begin
    state_n      = state_q;
    jump_done_n  = jump_done_q;
    illegal_n    = illegal_q;
    instr_req_o  = 1'b1;
    ctrl_busy_o  = 1'b1;
    pc_set_o     = 1'b0;
    pc_mux_o     = PC_BOOT;
    exc_cause_o  = '0;
    irq_ack_o    = 1'b0;
    exc_kill_o   = 1'b0;
    csr_o        = '0;
    halt_if_o    = 1'b0;
    halt_id_o    = 1'b0;
    dec_active_o = 1'b0;

    unique case (state_q)
      // wait for the core to be enabled
      RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_n = BOOT_SET;
        end
      end

      // load the boot address into the prefetcher
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_n  = FIRST_FETCH;
      end

      // first instruction still on its way
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_n = DECODE;
        end
        // pipeline is empty here, so the irq is taken from if
        if (irq_pending) begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_n   = IRQ_TAKEN_IF;
        end
      end

      DECODE: begin
        if (branch_taken_ex_i) begin
          // taken branch in ex wins over whatever sits in id
          pc_set_o = 1'b1;
          pc_mux_o = PC_BRANCH;
        end else if (instr_valid_i) begin
          dec_active_o = ~dec_i.illegal;
          if (irq_pending) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_n   = IRQ_FLUSH;
          end else if (dec_i.illegal) begin
            halt_if_o        = 1'b1;
            halt_id_o        = 1'b1;
            csr_o.save_id    = 1'b1;
            csr_o.save_cause = 1'b1;
            csr_o.cause      = EXC_ILLEGAL;
            illegal_n        = 1'b1;
            state_n          = FLUSH_EX;
          end else if (jump_in_dec) begin
            // target known in id, wait out a jr hazard, fire once
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_n = 1'b1;
            end
          end else if (dec_i.ebrk) begin
            halt_if_o        = 1'b1;
            halt_id_o        = 1'b1;
            csr_o.save_id    = 1'b1;
            csr_o.save_cause = 1'b1;
            csr_o.cause      = EXC_BREAKPOINT;
            state_n          = FLUSH_EX;
          end else if (dec_i.ecall) begin
            halt_if_o        = 1'b1;
            halt_id_o        = 1'b1;
            csr_o.save_id    = 1'b1;
            csr_o.save_cause = 1'b1;
            csr_o.cause      = EXC_ECALL_M;
            state_n          = FLUSH_EX;
          end else if (dec_i.mret) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_n   = FLUSH_EX;
          end
        end else begin
          // idle unless a conditional branch is still resolving
          ctrl_busy_o = (jump_in_id_i == JUMP_COND);
        end
      end

      // let the instruction in ex complete before touching csrs
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_n = FLUSH_WB;
        end
      end

      // ex and wb drained, redirect fetch
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        state_n   = DECODE;
        if (illegal_q) begin
          pc_set_o    = 1'b1;
          pc_mux_o    = PC_EXCEPTION;
          exc_cause_o = EXC_ILLEGAL;
          illegal_n   = 1'b0;
        end else if (dec_i.ebrk) begin
          pc_set_o    = 1'b1;
          pc_mux_o    = PC_EXCEPTION;
          exc_cause_o = EXC_BREAKPOINT;
        end else if (dec_i.ecall) begin
          pc_set_o    = 1'b1;
          pc_mux_o    = PC_EXCEPTION;
          exc_cause_o = EXC_ECALL_M;
        end else if (dec_i.mret) begin
          csr_o.restore_mret = 1'b1;
          state_n            = XRET_JUMP;
        end
      end

      // mepc restored, jump back
      XRET_JUMP: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_MRET;
        state_n  = DECODE;
      end

      // request may have been withdrawn, or mie cleared, meanwhile
      IRQ_FLUSH: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (irq_i && m_ie_i) begin
          state_n = IRQ_TAKEN_ID;
        end else begin
          exc_kill_o = 1'b1;
          state_n    = DECODE;
        end
      end

      // irq taken with the id pc as return address
      IRQ_TAKEN_ID: begin
        pc_set_o         = 1'b1;
        pc_mux_o         = PC_EXCEPTION;
        exc_cause_o      = CAUSE_W'(irq_id_i);
        csr_o.save_id    = 1'b1;
        csr_o.save_cause = 1'b1;
        csr_o.cause      = irq_cause;
        irq_ack_o        = 1'b1;
        state_n          = DECODE;
      end

      // irq taken with the if pc as return address
      IRQ_TAKEN_IF: begin
        pc_set_o         = 1'b1;
        pc_mux_o         = PC_EXCEPTION;
        exc_cause_o      = CAUSE_W'(irq_id_i);
        csr_o.save_if    = 1'b1;
        csr_o.save_cause = 1'b1;
        csr_o.cause      = irq_cause;
        irq_ack_o        = 1'b1;
        state_n          = DECODE;
      end

      default: begin
        instr_req_o = 1'b0;
        state_n     = RESET;
      end
    endcase
  end

  //////////////////////////////
  // state registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
      illegal_q   <= 1'b0;
    end else begin
      state_q     <= state_n;
      // held while id is stalled, released once the jump leaves id
      jump_done_q <= jump_done_n & ~id_ready_i;
      illegal_q   <= illegal_n;
    end
  end

endmodule

/* src/hazard_pkg.sv */
//////////////////////////////
// hazard and forwarding types: operand hits, later-stage
// write status and operand source selects
//////////////////////////////

package hazard_pkg;

  // destination of a stage matches source of operand a, b or c
  typedef struct packed {
    logic a;
    logic b;
    logic c;
  } op_hit_t;

  // write status of the ex and wb stages
  typedef struct packed {
    // ex stage writes the regfile
    logic ex_we;
    // ex stage has a memory request in flight
    logic ex_data_req;
    // wb stage writes the regfile
    logic wb_we;
    // wb stage can accept, low while a load is outstanding
    logic wb_ready;
    // alu or mult result available for forwarding
    logic alu_we_fw;
  } pipe_wr_t;

  // operand source in the id stage
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'd0,
    SEL_FW_EX   = 2'd1,
    SEL_FW_WB   = 2'd2
  } fwd_sel_e;

  // one select per operand
  typedef struct packed {
    fwd_sel_e a;
    fwd_sel_e b;
    fwd_sel_e c;
  } fwd_sel_t;

endpackage

/* src/ctrl_pkg.sv */
//////////////////////////////
// controller types: fsm states, pc select, jump kinds,
// exception causes, decoder flags and csr commands
//////////////////////////////

package ctrl_pkg;

  // width of a trap cause as seen by the csr file
  localparam int CAUSE_W = 6;

  // main controller states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    FIRST_FETCH,
    DECODE,
    IRQ_FLUSH,
    IRQ_TAKEN_ID,
    IRQ_TAKEN_IF,
    FLUSH_EX,
    FLUSH_WB,
    XRET_JUMP
  } ctrl_state_e;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_EXCEPTION,
    PC_MRET
  } pc_mux_e;

  // jump class, as reported by the decoder
  typedef enum logic [1:0] {
    JUMP_NONE,
    JUMP_JAL,
    JUMP_JALR,
    JUMP_COND
  } jump_kind_e;

  // synchronous causes only, interrupts set the top bit above the id
  typedef enum logic [CAUSE_W-1:0] {
    EXC_ILLEGAL    = 6'd2,
    EXC_BREAKPOINT = 6'd3,
    EXC_ECALL_M    = 6'd11
  } exc_cause_e;

  // decoder flags for the instruction in id
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic ebrk;
    logic mret;
  } dec_flags_t;

  // commands towards the csr file
  typedef struct packed {
    logic               save_if;
    logic               save_id;
    logic               save_cause;
    logic               restore_mret;
    logic [CAUSE_W-1:0] cause;
  } csr_cmd_t;

endpackage
